// ==== include/fp_pipe_cfg.svh ====
`ifndef FP_PIPE_CFG_SVH
`define FP_PIPE_CFG_SVH

// Width of an FP register and of every data word in the pipeline
`define FP_XLEN 32

// Set to 1 to build the EX and MEM bypass paths into ID operand selection
`define FP_FWD_FP 1

// Set to 1 so a register file read sees the WB write of the same cycle
`define FP_FWD_REGFILE 1

// Memory type encodings. SRAM returns load data in MEM and BRAM only in WB
`define FP_MEM_TYPE_SRAM 0
`define FP_MEM_TYPE_BRAM 1
`define FP_MEM_TYPE `FP_MEM_TYPE_SRAM

`endif

// ==== rtl/fp_isa_pkg.sv ====
`default_nettype none

`include "fp_pipe_cfg.svh"

package fp_isa_pkg;

  // Operation kinds that reach the FP pipeline
  typedef enum logic {
    FP_OP_LOAD    = 1'b0,
    FP_OP_COMPUTE = 1'b1
  } fp_op_e;

  typedef logic [4:0]          fp_reg_t;
  typedef logic [`FP_XLEN-1:0] fp_data_t;

  // Pre-decoded FP instruction as it sits in ID
  // A load carries the word the data memory would have returned
  typedef struct packed {
    fp_op_e   op;
    fp_reg_t  rd;
    fp_reg_t  rs1;
    fp_reg_t  rs2;
    fp_reg_t  rs3;
    logic     rs1_used;
    logic     rs2_used;
    logic     rs3_used;
    logic     reg_write;
    fp_data_t load_data;
  } fp_instr_t;

endpackage

`default_nettype wire

// ==== rtl/fp_pipe_pkg.sv ====
`default_nettype none

package fp_pipe_pkg;

  import fp_isa_pkg::*;

  // ID/EX payload
  // Operands are already resolved through the bypass network in ID
  // Index 0 holds rs1, index 1 rs2 and index 2 rs3
  typedef struct packed {
    logic                 valid;
    fp_op_e               op;
    fp_reg_t              rd;
    logic                 reg_write;
    fp_data_t [2:0]       opnd;
    fp_data_t             load_data;
  } ex_stage_t;

  // EX/MEM payload
  // For a load the result already holds the memory word
  typedef struct packed {
    logic     valid;
    logic     is_load;
    fp_reg_t  rd;
    logic     reg_write;
    fp_data_t result;
  } mem_stage_t;

  // MEM/WB payload and the retirement record at the top level ports
  typedef struct packed {
    logic     valid;
    logic     is_load;
    fp_reg_t  rd;
    logic     reg_write;
    fp_data_t result;
  } wb_stage_t;

endpackage

`default_nettype wire

// ==== rtl/fp_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// One pipeline boundary register
// The payload type must carry a valid bit named valid
module fp_stage_reg
  import fp_pipe_pkg::*;
#(
  parameter type payload_t = mem_stage_t
) (
  input  wire logic     clk,
  input  wire logic     arst_n,
  input  wire logic     bubble,
  input  wire payload_t d,
  output payload_t      q
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // Every stage starts out empty
      q <= '0;
    end else begin
      q <= d;
      // A bubble keeps the fields but marks the slot as empty
      if (bubble) begin
        q.valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fp_hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_pipe_cfg.svh"

// Data hazard detection for the FP instruction in ID
// Produces the level that holds the instruction in ID and sends a bubble to EX
module fp_hazard
  import fp_isa_pkg::*;
  import fp_pipe_pkg::*;
#(
  parameter int fwd_fp      = `FP_FWD_FP,
  parameter int fwd_regfile = `FP_FWD_REGFILE,
  parameter int mem_type    = `FP_MEM_TYPE
) (
  input  wire fp_instr_t  id_instr,
  input  wire ex_stage_t  ex_stage,
  input  wire mem_stage_t mem_stage,
  input  wire wb_stage_t  wb_stage,
  input  wire logic       control_flush,
  output logic            fp_data_hazard_id
);

  // True when any source that ID actually reads names the given register
  function automatic logic src_hit(fp_instr_t ins, fp_reg_t rd);
    src_hit = (ins.rs1_used && (ins.rs1 == rd)) ||
              (ins.rs2_used && (ins.rs2 == rd)) ||
              (ins.rs3_used && (ins.rs3 == rd));
  endfunction

  logic ex_hit;
  logic mem_hit;
  logic wb_hit;
  logic ex_load_use;
  logic mem_load_use;
  logic stall;

  // RAW matches against every older instruction that will write an FP register
  assign ex_hit  = ex_stage.valid && ex_stage.reg_write && src_hit(id_instr, ex_stage.rd);
  assign mem_hit = mem_stage.valid && mem_stage.reg_write &&
                   src_hit(id_instr, mem_stage.rd);
  assign wb_hit  = wb_stage.valid && wb_stage.reg_write && src_hit(id_instr, wb_stage.rd);

  // A load in EX never has its data ready for ID
  assign ex_load_use  = ex_hit && (ex_stage.op == FP_OP_LOAD);

  // BRAM returns the word only at the end of MEM so ID has to wait one more cycle
  assign mem_load_use = mem_hit && mem_stage.is_load && (mem_type == `FP_MEM_TYPE_BRAM);

  always_comb begin
    stall = 1'b0;
    if (fwd_fp != 0) begin
      // Compute results and SRAM loads reach ID through the bypass
      stall = ex_load_use || mem_load_use;
    end else begin
      // No bypass at all so any pending writer blocks ID
      stall = ex_hit || mem_hit;
    end
    // The WB write is only visible in the same cycle when the register file passes it on
    if ((fwd_regfile == 0) && wb_hit) begin
      stall = 1'b1;
    end
  end

  // A flushed instruction never waits
  assign fp_data_hazard_id = stall && !control_flush;

endmodule

`default_nettype wire

// ==== rtl/fp_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_pipe_cfg.svh"

// ID operand bypass and the EX result of the stand-in datapath
module fp_execute
  import fp_isa_pkg::*;
  import fp_pipe_pkg::*;
#(
  parameter int fwd_fp   = `FP_FWD_FP,
  parameter int mem_type = `FP_MEM_TYPE
) (
  input  wire fp_instr_t      id_instr,
  input  wire fp_data_t [2:0] rf_data,
  input  wire ex_stage_t      ex_stage,
  input  wire mem_stage_t     mem_stage,
  output fp_data_t [2:0]      id_operands,
  output fp_data_t            ex_result
);

  fp_reg_t [2:0] src;
  logic    [2:0] used;
  logic          ex_fwd_ok;
  logic          mem_fwd_ok;

  assign src  = {id_instr.rs3, id_instr.rs2, id_instr.rs1};
  assign used = {id_instr.rs3_used, id_instr.rs2_used, id_instr.rs1_used};

  // Loads pass the memory word and compute sums all three operands with wrap
  assign ex_result = (ex_stage.op == FP_OP_LOAD) ? ex_stage.load_data :
                     ex_stage.opnd[0] + ex_stage.opnd[1] + ex_stage.opnd[2];

  // Only a compute result is ready in EX
  assign ex_fwd_ok  = ex_stage.valid && ex_stage.reg_write && (ex_stage.op == FP_OP_COMPUTE);

  // MEM loads can be bypassed only when the memory answers within MEM
  assign mem_fwd_ok = mem_stage.valid && mem_stage.reg_write &&
                      (!mem_stage.is_load || (mem_type == `FP_MEM_TYPE_SRAM));

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      id_operands[i] = rf_data[i];
      if (fwd_fp != 0) begin
        // EX is checked last so the youngest writer wins
        if (mem_fwd_ok && (mem_stage.rd == src[i])) id_operands[i] = mem_stage.result;
        if (ex_fwd_ok && (ex_stage.rd == src[i])) id_operands[i] = ex_result;
      end
      // A source the instruction does not read contributes zero to the sum
      if (!used[i]) begin
        id_operands[i] = '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fp_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_pipe_cfg.svh"

// FP register file with one write port from WB and three read ports for ID
module fp_regfile
  import fp_isa_pkg::*;
  import fp_pipe_pkg::*;
#(
  parameter int fwd_regfile = `FP_FWD_REGFILE
) (
  input  wire logic      clk,
  input  wire logic      arst_n,
  input  wire wb_stage_t wr,
  input  wire fp_reg_t   rs1,
  input  wire fp_reg_t   rs2,
  input  wire fp_reg_t   rs3,
  output fp_data_t       rd1,
  output fp_data_t       rd2,
  output fp_data_t       rd3
);

  fp_data_t regs [32];
  logic     wr_en;

  // Unlike the integer file, f0 is an ordinary register
  assign wr_en = wr.valid && wr.reg_write;

  // Read with optional pass-through of the write in flight
  function automatic fp_data_t read_port(fp_reg_t idx);
    if ((fwd_regfile != 0) && wr_en && (wr.rd == idx)) begin
      read_port = wr.result;
    end else begin
      read_port = regs[idx];
    end
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // All registers read as zero after reset
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr.rd] <= wr.result;
    end
  end

  assign rd1 = read_port(rs1);
  assign rd2 = read_port(rs2);
  assign rd3 = read_port(rs3);

endmodule

`default_nettype wire

// ==== rtl/fp_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_pipe_cfg.svh"

// FP side of a four-stage ID/EX/MEM/WB pipeline
// ID is the instruction on the input port and the three registers hold EX, MEM and WB
module fp_pipe_top
  import fp_isa_pkg::*;
  import fp_pipe_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      arst_n,
  input  wire logic      instr_valid,
  input  wire fp_instr_t instr,
  input  wire logic      control_flush,
  output logic           id_stall,
  output logic           retire_valid,
  output wb_stage_t      retire
);

  fp_instr_t      id_instr;
  fp_data_t [2:0] rf_data;
  fp_data_t [2:0] id_operands;
  fp_data_t       ex_result;
  ex_stage_t      ex_d;
  ex_stage_t      ex_q;
  mem_stage_t     mem_d;
  mem_stage_t     mem_q;
  wb_stage_t      wb_d;
  wb_stage_t      wb_q;

  // An empty ID slot reads nothing and writes nothing so it cannot raise a hazard
  always_comb begin
    id_instr = instr;
    if (!instr_valid) begin
      id_instr.rs1_used  = 1'b0;
      id_instr.rs2_used  = 1'b0;
      id_instr.rs3_used  = 1'b0;
      id_instr.reg_write = 1'b0;
    end
  end

  fp_hazard #(
    .fwd_fp      (`FP_FWD_FP),
    .fwd_regfile (`FP_FWD_REGFILE),
    .mem_type    (`FP_MEM_TYPE)
  ) u_hazard (
    .id_instr          (id_instr),
    .ex_stage          (ex_q),
    .mem_stage         (mem_q),
    .wb_stage          (wb_q),
    .control_flush     (control_flush),
    .fp_data_hazard_id (id_stall)
  );

  fp_regfile #(
    .fwd_regfile (`FP_FWD_REGFILE)
  ) u_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (wb_q),
    .rs1    (id_instr.rs1),
    .rs2    (id_instr.rs2),
    .rs3    (id_instr.rs3),
    .rd1    (rf_data[0]),
    .rd2    (rf_data[1]),
    .rd3    (rf_data[2])
  );

  fp_execute #(
    .fwd_fp   (`FP_FWD_FP),
    .mem_type (`FP_MEM_TYPE)
  ) u_execute (
    .id_instr    (id_instr),
    .rf_data     (rf_data),
    .ex_stage    (ex_q),
    .mem_stage   (mem_q),
    .id_operands (id_operands),
    .ex_result   (ex_result)
  );

  // A flushed instruction enters EX as an empty slot
  // A stall turns the slot into a bubble inside the stage register
  always_comb begin
    ex_d.valid     = instr_valid && !control_flush;
    ex_d.op        = id_instr.op;
    ex_d.rd        = id_instr.rd;
    ex_d.reg_write = id_instr.reg_write;
    ex_d.opnd      = id_operands;
    ex_d.load_data = id_instr.load_data;
  end

  fp_stage_reg #(.payload_t(ex_stage_t)) u_id_ex (
    .clk (clk), .arst_n (arst_n), .bubble (id_stall), .d (ex_d), .q (ex_q)
  );

  // MEM does no work of its own since the load word already rides in the payload
  always_comb begin
    mem_d.valid     = ex_q.valid;
    mem_d.is_load   = (ex_q.op == FP_OP_LOAD);
    mem_d.rd        = ex_q.rd;
    mem_d.reg_write = ex_q.reg_write;
    mem_d.result    = ex_result;
  end

  // Nothing stalls past ID so the later boundaries always advance
  fp_stage_reg #(.payload_t(mem_stage_t)) u_ex_mem (
    .clk (clk), .arst_n (arst_n), .bubble (1'b0), .d (mem_d), .q (mem_q)
  );

  always_comb begin
    wb_d.valid     = mem_q.valid;
    wb_d.is_load   = mem_q.is_load;
    wb_d.rd        = mem_q.rd;
    wb_d.reg_write = mem_q.reg_write;
    wb_d.result    = mem_q.result;
  end

  fp_stage_reg #(.payload_t(wb_stage_t)) u_mem_wb (
    .clk (clk), .arst_n (arst_n), .bubble (1'b0), .d (wb_d), .q (wb_q)
  );

  // Retirement is the register file write of this cycle
  assign retire       = wb_q;
  assign retire_valid = wb_q.valid && wb_q.reg_write;

endmodule

`default_nettype wire

// ==== test/fp_pipe_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the FP pipeline top
module fp_pipe_asserts (
  input wire logic clk,
  input wire logic arst_n,
  input wire logic control_flush,
  input wire logic id_stall,
  input wire logic retire_valid
);

  // Number of assertion failures seen so far
  int fail_count = 0;

  // A flushed ID instruction has nothing to wait for
  flush_no_stall: assert property (@(posedge clk) disable iff (!arst_n)
    control_flush |-> !id_stall)
    else begin
      fail_count++;
      $error("id_stall high in a cycle with control_flush");
    end

  // Reset empties every stage so nothing can retire
  reset_no_retire: assert property (@(posedge clk) !arst_n |-> !retire_valid)
    else begin
      fail_count++;
      $error("retire_valid high during reset");
    end

  // The blocking writer leaves WB within three cycles at the latest
  stall_bounded: assert property (@(posedge clk) disable iff (!arst_n)
    !(id_stall && $past(id_stall) && $past(id_stall, 2) && $past(id_stall, 3)))
    else begin
      fail_count++;
      $error("id_stall held for more than three cycles");
    end

endmodule

bind fp_pipe_top fp_pipe_asserts u_asserts (
  .clk           (clk),
  .arst_n        (arst_n),
  .control_flush (control_flush),
  .id_stall      (id_stall),
  .retire_valid  (retire_valid)
);

`default_nettype wire

// ==== test/fp_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_pipe_cfg.svh"

// Testbench for the FP pipeline top
// An architectural register array predicts every retirement in program order
module fp_pipe_tb
  import fp_isa_pkg::*;
  import fp_pipe_pkg::*;
();

  logic      clk;
  logic      arst_n;
  logic      instr_valid;
  fp_instr_t instr;
  logic      control_flush;
  logic      id_stall;
  logic      retire_valid;
  wb_stage_t retire;

  // Architectural state and the retirements still expected, oldest first
  fp_data_t arch [32];
  fp_reg_t  exp_rd [$];
  fp_data_t exp_val [$];
  logic     exp_load [$];
  int       exp_cycle [$];

  int     cycle = 0;
  int     stall_cycles;
  integer seed;

  fp_pipe_top DUT (
    .clk           (clk),
    .arst_n        (arst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .control_flush (control_flush),
    .id_stall      (id_stall),
    .retire_valid  (retire_valid),
    .retire        (retire)
  );

  // 4 ns period
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic report_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      report_failure();
    end
  endtask

  // Loads return their data word and compute sums the sources it reads with wrap
  function automatic fp_data_t model_value(fp_instr_t ins);
    fp_data_t sum;
    sum = '0;
    if (ins.op == FP_OP_LOAD) begin
      return ins.load_data;
    end
    if (ins.rs1_used) sum += arch[ins.rs1];
    if (ins.rs2_used) sum += arch[ins.rs2];
    if (ins.rs3_used) sum += arch[ins.rs3];
    return sum;
  endfunction

  // Stall cycles for n back-to-back computes that each read the previous result
  function automatic int chain_stalls(int n);
    if (`FP_FWD_FP != 0) begin
      return 0;
    end
    return (n - 1) * ((`FP_FWD_REGFILE != 0) ? 2 : 3);
  endfunction

  function automatic fp_instr_t make_instr(fp_op_e op, fp_reg_t rd, fp_reg_t rs1,
                                           fp_reg_t rs2, fp_reg_t rs3, logic [2:0] used,
                                           fp_data_t data);
    fp_instr_t ins;
    ins.op        = op;
    ins.rd        = rd;
    ins.rs1       = rs1;
    ins.rs2       = rs2;
    ins.rs3       = rs3;
    ins.rs1_used  = used[0];
    ins.rs2_used  = used[1];
    ins.rs3_used  = used[2];
    ins.reg_write = 1'b1;
    ins.load_data = data;
    return ins;
  endfunction

  // Acceptance updates the model at once since older instructions already did
  task automatic accept(input fp_instr_t ins);
    fp_data_t value;
    value = model_value(ins);
    if (ins.reg_write) begin
      exp_rd.push_back(ins.rd);
      exp_val.push_back(value);
      exp_load.push_back(ins.op == FP_OP_LOAD);
      exp_cycle.push_back(cycle);
      arch[ins.rd] = value;
    end
  endtask

  // Presents one instruction and holds it while ID is stalled
  task automatic issue(input fp_instr_t ins, input logic flush);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk);
      instr_valid   = 1'b1;
      instr         = ins;
      control_flush = flush;
      // id_stall is settled here and stays so until the rising edge
      #1;
      if (flush) begin
        done = 1'b1;
      end else if (!id_stall) begin
        accept(ins);
        done = 1'b1;
      end else begin
        stall_cycles++;
        waited++;
        if (waited > 8) begin
          $display("Instruction for f%0d held in ID for more than 8 cycles", ins.rd);
          report_failure();
        end
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      instr_valid   = 1'b0;
      control_flush = 1'b0;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    idle(1);
    while (exp_rd.size() != 0) begin
      @(negedge clk);
      #1;
      waited++;
      if (waited > 10) begin
        $display("Pipeline stopped retiring with %0d results outstanding", exp_rd.size());
        report_failure();
      end
    end
  endtask

  // Register indices come from f0 to f7 so that hazards are frequent
  task automatic random_step();
    logic [31:0] r;
    fp_instr_t   ins;
    r = $random(seed);
    ins.op        = r[15] ? FP_OP_COMPUTE : FP_OP_LOAD;
    ins.rd        = {2'b00, r[2:0]};
    ins.rs1       = {2'b00, r[5:3]};
    ins.rs2       = {2'b00, r[8:6]};
    ins.rs3       = {2'b00, r[11:9]};
    // A load reads no FP register
    ins.rs1_used  = r[12] && r[15];
    ins.rs2_used  = r[13] && r[15];
    ins.rs3_used  = r[14] && r[15];
    ins.reg_write = (r[19:16] != 4'd0);
    ins.load_data = $random(seed);
    if (r[26:24] == 3'd0) begin
      idle(1 + int'(r[28:27]));
    end
    issue(ins, r[23:20] == 4'd0);
  endtask

  // Each retirement is written on the third edge after the accepting one
  task automatic check_retirement();
    if (exp_rd.size() == 0) begin
      $display("Retirement of f%0d with no instruction outstanding", retire.rd);
      report_failure();
    end else begin
      check("retire.rd", 32'(retire.rd), 32'(exp_rd.pop_front()));
      check("retire.result", retire.result, exp_val.pop_front());
      check("retire.is_load", 32'(retire.is_load), 32'(exp_load.pop_front()));
      check("retire_latency", 32'(cycle - exp_cycle.pop_front()), 32'd3);
    end
  endtask

  always @(negedge clk) begin
    if (arst_n && retire_valid) begin
      check_retirement();
    end
  end

  // The bound checker counts its failures so the run stops right after one
  always @(negedge clk) begin
    if (DUT.u_asserts.fail_count != 0) begin
      $display("An assertion on the pipeline top failed");
      report_failure();
    end
  end

  initial begin
    clk           = 1'b0;
    arst_n        = 1'b0;
    instr_valid   = 1'b0;
    instr         = '0;
    control_flush = 1'b0;
    stall_cycles  = 0;
    seed          = 32'hef67;
    for (int i = 0; i < 32; i++) begin
      arch[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Independent loads into f20 to f23, then computes that only read them
    for (int i = 0; i < 4; i++) begin
      issue(make_instr(FP_OP_LOAD, fp_reg_t'(20 + i), 5'd0, 5'd0, 5'd0, 3'b000,
                       32'h3f80_0000 + 32'(i * 7)), 1'b0);
    end
    drain();
    stall_cycles = 0;
    for (int i = 0; i < 8; i++) begin
      issue(make_instr(FP_OP_COMPUTE, fp_reg_t'(i), fp_reg_t'(20 + i % 4), 5'd21, 5'd22,
                       3'b111, '0), 1'b0);
    end
    drain();
    check("stall_cycles", 32'(stall_cycles), 32'd0);

    // Back-to-back compute chain through f5
    stall_cycles = 0;
    for (int i = 0; i < 6; i++) begin
      issue(make_instr(FP_OP_COMPUTE, 5'd5, 5'd5, 5'd20, 5'd21, 3'b111, '0), 1'b0);
    end
    drain();
    if ((`FP_FWD_FP == 0) || (`FP_FWD_REGFILE != 0)) begin
      check("stall_cycles", 32'(stall_cycles), 32'(chain_stalls(6)));
    end

    // Consumer right behind a load
    stall_cycles = 0;
    issue(make_instr(FP_OP_LOAD, 5'd6, 5'd0, 5'd0, 5'd0, 3'b000, 32'h1234_5678), 1'b0);
    issue(make_instr(FP_OP_COMPUTE, 5'd7, 5'd6, 5'd20, 5'd21, 3'b111, '0), 1'b0);
    drain();
    check("load_use_stalled", 32'(stall_cycles != 0), 32'd1);

    // The flushed load must leave f8 untouched for its reader
    issue(make_instr(FP_OP_LOAD, 5'd8, 5'd0, 5'd0, 5'd0, 3'b000, 32'hdead_beef), 1'b1);
    issue(make_instr(FP_OP_COMPUTE, 5'd9, 5'd8, 5'd20, 5'd0, 3'b011, '0), 1'b0);
    drain();

    repeat (2000) begin
      random_step();
    end
    drain();

    // Read back every register through a compute that rewrites it unchanged
    for (int r = 0; r < 32; r++) begin
      issue(make_instr(FP_OP_COMPUTE, fp_reg_t'(r), fp_reg_t'(r), 5'd0, 5'd0, 3'b001, '0),
            1'b0);
    end
    drain();
    idle(4);
    check("assertion_failures", 32'(DUT.u_asserts.fail_count), 32'd0);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
rtl/fp_isa_pkg.sv
rtl/fp_pipe_pkg.sv
rtl/fp_stage_reg.sv
rtl/fp_hazard.sv
rtl/fp_execute.sv
rtl/fp_regfile.sv
rtl/fp_pipe_top.sv
test/fp_pipe_asserts.sv
test/fp_pipe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := fp_pipe_tb
FILELIST  := sim.f
FLAGS     := --timing --assert
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the log holds the pass message
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
